// File: i8008_core.f
design/i8008_pkg.sv
design/fsm_decoder.sv
design/bus_datapath.sv
design/reg_file.sv
design/alu.sv
design/program_counter.sv
design/i8008_core.sv
tests/tb_clock.sv
tests/i8008_core_tb.sv

// File: tests/i8008_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_core_tb;

  localparam int NUM_INSTR = 60;
  localparam int MAX_WAIT  = 8;
  localparam int MEM_SIZE  = 1 << i8008_pkg::ADDR_W;

  // One expected bus cycle, or one OUT pair when ctype is PCC
  typedef struct packed {
    i8008_pkg::ctype_t ctype;
    logic [13:0]       addr;
    logic [7:0]        data;
    logic [7:0]        op;
  } event_t;

  logic              clk;
  logic              rst;
  logic [7:0]        d_in;
  logic              ready;
  logic [7:0]        d_out;
  logic              sync;
  i8008_pkg::state_t state;

  logic [7:0]        mem [MEM_SIZE];
  event_t            exp_q [$];
  logic [7:0]        m_regs [7];   // Instruction-set model state
  i8008_pkg::flags_t m_flags;
  logic [13:0]       m_pc;
  logic              m_halted;
  int                ptr;
  int                limit;
  int                cycles;
  int                wait_run;
  logic [7:0]        lo_q;
  logic [7:0]        mon_lo;
  logic              prev_stall;   // Last state was T2 or WAIT of a memory cycle
  logic              prev_ready;

  tb_clock u_clk (.clk, .rst);

  i8008_core uut (.clk, .rst, .d_in, .ready, .d_out, .sync, .state);

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_addr(input i8008_pkg::ctype_t exp_t, input i8008_pkg::ctype_t act_t,
                            input logic [13:0] exp_a, input logic [13:0] act_a);
    if (act_t !== exp_t)
      abort_run($sformatf("ERROR time=%0t signal=cycle_type expected=%s actual=%s",
                          $time, exp_t.name(), act_t.name()));
    else if (act_a !== exp_a)
      abort_run($sformatf("ERROR time=%0t signal=address expected=%h actual=%h",
                          $time, exp_a, act_a));
  endtask

  task automatic check_out(input logic [7:0] exp_d, input logic [7:0] act_d,
                           input i8008_pkg::instr_u exp_i, input i8008_pkg::instr_u act_i);
    if (act_d !== exp_d)
      abort_run($sformatf("ERROR time=%0t signal=out_data expected=%h actual=%h",
                          $time, exp_d, act_d));
    else if (act_i !== exp_i)
      abort_run($sformatf("ERROR time=%0t signal=out_instr expected=%h actual=%h",
                          $time, exp_i, act_i));
  endtask

  task automatic check_state(input i8008_pkg::state_t exp_s, input i8008_pkg::state_t act_s);
    if (act_s !== exp_s)
      abort_run($sformatf("ERROR time=%0t signal=state expected=%s actual=%s",
                          $time, exp_s.name(), act_s.name()));
  endtask

  function automatic i8008_pkg::flags_t zsp_flags(input logic [7:0] res, input logic cy);
    i8008_pkg::flags_t f;
    f.carry = cy;
    f.zero = (res == 8'd0);
    f.sign = res[7];
    f.parity = ($countones(res) % 2) == 0;
    return f;
  endfunction

  // Operand codes follow the 8008 field order ADD ADC SUB SBB AND XOR OR CMP
  function automatic logic [7:0] ref_alu(input logic [2:0] op, input logic [7:0] a,
                                         input logic [7:0] b);
    int r;
    case (op)
      3'd0: r = a + b;
      3'd1: r = a + b + m_flags.carry;
      3'd3: r = a - b - m_flags.carry;
      3'd4: r = a & b;
      3'd5: r = a ^ b;
      3'd6: r = a | b;
      default: r = a - b;
    endcase
    m_flags = zsp_flags(r[7:0], (r < 0) || (r > 255));
    return (op == 3'd7) ? a : r[7:0];
  endfunction

  function automatic void push_event(input i8008_pkg::ctype_t t, input logic [13:0] a,
                                     input logic [7:0] d, input logic [7:0] op);
    event_t e;
    e.ctype = t;
    e.addr = a;
    e.data = d;
    e.op = op;
    exp_q.push_back(e);
  endfunction

  function automatic void ref_step();
    logic [7:0] op;
    logic [7:0] v;
    logic [7:0] a;
    logic [2:0] ddd;
    logic [2:0] sss;
    logic       taken;
    op = mem[m_pc];
    ddd = op[5:3];
    sss = op[2:0];
    a = m_regs[0];
    push_event(i8008_pkg::PCI, m_pc, 8'd0, 8'd0);
    m_pc = m_pc + 1;
    if (op == 8'h00 || op == 8'h01 || op == 8'hFF) begin
      m_halted = 1'b1;
    end else if (op[7:6] == 2'b11) begin
      m_regs[ddd] = m_regs[sss];
    end else if (op[7:6] == 2'b10) begin
      m_regs[0] = ref_alu(ddd, a, m_regs[sss]);
    end else if (op[7:6] == 2'b00) begin
      if (sss == 3'b110 || sss == 3'b100) begin
        push_event(i8008_pkg::PCR, m_pc, 8'd0, 8'd0);
        v = mem[m_pc];
        m_pc = m_pc + 1;
        if (sss == 3'b110) m_regs[ddd] = v;
        else m_regs[0] = ref_alu(ddd, a, v);
      end else if (sss == 3'b010) begin
        case (ddd[1:0])
          2'd0: m_regs[0] = {a[6:0], a[7]};
          2'd1: m_regs[0] = {a[0], a[7:1]};
          2'd2: m_regs[0] = {a[6:0], m_flags.carry};
          default: m_regs[0] = {m_flags.carry, a[7:1]};
        endcase
        m_flags.carry = ddd[0] ? a[0] : a[7];  // Bit shifted out
      end else begin
        v = sss[0] ? m_regs[ddd] - 8'd1 : m_regs[ddd] + 8'd1;
        m_regs[ddd] = v;
        m_flags = zsp_flags(v, m_flags.carry);
      end
    end else if (op[0]) begin
      push_event(i8008_pkg::PCC, 14'd0, a, op);
    end else begin
      push_event(i8008_pkg::PCR, m_pc, 8'd0, 8'd0);
      push_event(i8008_pkg::PCR, m_pc + 14'd1, 8'd0, 8'd0);
      case (op[4:3])
        2'd0: taken = m_flags.carry;
        2'd1: taken = m_flags.zero;
        2'd2: taken = m_flags.sign;
        default: taken = m_flags.parity;
      endcase
      taken = (sss == 3'b100) || (taken == op[5]);
      v = mem[m_pc];
      a = mem[m_pc + 14'd1];
      m_pc = taken ? {a[5:0], v} : m_pc + 14'd2;
    end
  endfunction

  task automatic emit(input logic [7:0] b);
    mem[ptr] = b;
    ptr++;
  endtask

  function automatic logic [7:0] out_op();
    return {2'b01, 3'($urandom_range(2, 7)), 2'($urandom), 1'b1};
  endfunction

  task automatic build_program();
    int         kind;
    int         skip;
    logic [13:0] target;
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = i[7:0] ^ {i[13:8], 2'b10};  // Never executed
    end
    ptr = 0;
    for (int i = 0; i < NUM_INSTR; i++) begin
      kind = $urandom_range(0, 7);
      case (kind)
        0: emit({2'b11, 3'($urandom_range(0, 6)), 3'($urandom_range(0, 6))});
        1: begin
          emit({2'b00, 3'($urandom_range(0, 6)), 3'b110});
          emit(8'($urandom));
        end
        2: emit({2'b00, 3'($urandom_range(1, 6)), 2'b00, 1'($urandom)});
        3: emit({2'b10, 3'($urandom), 3'($urandom_range(0, 6))});
        4: begin
          emit({2'b00, 3'($urandom), 3'b100});
          emit(8'($urandom));
        end
        5: emit({3'b000, 2'($urandom), 3'b010});
        6: begin
          skip = $urandom_range(0, 2);
          target = 14'(ptr + 3 + skip);  // Forward target past the skipped OUT bytes
          if ($urandom_range(0, 4) == 0) emit(i8008_pkg::OP_JMP);
          else emit({2'b01, 3'($urandom), 3'b000});
          emit(target[7:0]);
          emit({2'b00, target[13:8]});
          repeat (skip) emit(out_op());
        end
        default: ;
      endcase
      if (kind != 6) emit(out_op());  // Show the accumulator
    end
    emit(i8008_pkg::OP_HLT2);
  endtask

  // Memory model
  always @(posedge clk) begin
    if (state == i8008_pkg::T1) lo_q <= d_out;
    else if (state == i8008_pkg::T2) d_in <= mem[{d_out[5:0], lo_q}];
  end

  always @(posedge clk) begin
    if (wait_run >= MAX_WAIT - 1 || $urandom_range(0, 9) >= 3) begin
      ready <= 1'b1;
      wait_run <= 0;
    end else begin
      ready <= 1'b0;
      wait_run <= wait_run + 1;
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles <= cycles + 1;
      if (cycles >= limit) abort_run("program did not reach HLT");
    end
  end

  task automatic compare_cycle(input logic [7:0] lo, input logic [7:0] hi);
    event_t            e;
    i8008_pkg::ctype_t act_t;
    act_t = i8008_pkg::ctype_t'(hi[7:6]);
    if (exp_q.size() == 0) begin
      abort_run($sformatf("bus cycle at time %0t after the last expected one", $time));
    end else begin
      e = exp_q.pop_front();
      if ((e.ctype == i8008_pkg::PCC) != (act_t == i8008_pkg::PCC))
        abort_run($sformatf("output cycle and memory cycle out of order at time %0t", $time));
      else if (e.ctype == i8008_pkg::PCC)
        check_out(e.data, lo, i8008_pkg::instr_u'(e.op), i8008_pkg::instr_u'(hi));
      else
        check_addr(e.ctype, act_t, e.addr, {hi[5:0], lo});
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      // Ready seen at the last edge decides between T3 and one more WAIT
      if (prev_stall) check_state(prev_ready ? i8008_pkg::T3 : i8008_pkg::WAIT, state);
      if (state == i8008_pkg::T1) begin
        if (!sync) abort_run("sync was low during T1");
        mon_lo = d_out;
      end else if (state == i8008_pkg::T2) begin
        if (!sync) abort_run("sync was low during T2");
        compare_cycle(mon_lo, d_out);
      end else if (sync) begin
        abort_run("sync was high outside T1 and T2");
      end
      prev_stall = (state == i8008_pkg::WAIT) ||
                   (state == i8008_pkg::T2 &&
                    i8008_pkg::ctype_t'(d_out[7:6]) != i8008_pkg::PCC);
      prev_ready = ready;
    end
  end

  initial begin
    d_in = 8'd0;
    ready = 1'b1;
    wait_run = 0;
    cycles = 0;
    prev_stall = 1'b0;
    prev_ready = 1'b1;
    void'($urandom(1149));
    build_program();
    for (int i = 0; i < 7; i++) m_regs[i] = 8'd0;
    m_flags = '0;
    m_pc = '0;
    m_halted = 1'b0;
    while (!m_halted) ref_step();
    limit = ptr * 3 * (5 + MAX_WAIT) + 200;
    @(negedge clk);
    while (rst) @(negedge clk);
    while (state !== i8008_pkg::STOPPED) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      check_state(i8008_pkg::STOPPED, state);
      if (sync) abort_run("sync pulsed after HLT");
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected bus cycles never happened", exp_q.size()));
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: design/i8008_core.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_core (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [i8008_pkg::DATA_W-1:0] d_in,
  input  logic                         ready,
  output logic [i8008_pkg::DATA_W-1:0] d_out,
  output logic                         sync,
  output i8008_pkg::state_t            state
);

  i8008_pkg::ctrl_t            ctrl;
  i8008_pkg::instr_u           instr;
  i8008_pkg::flags_t           flags;
  logic [i8008_pkg::DATA_W-1:0] bus;
  logic [i8008_pkg::DATA_W-1:0] rf_out;
  logic [i8008_pkg::DATA_W-1:0] alu_out;
  logic [i8008_pkg::DATA_W-1:0] pc_byte;
  logic [i8008_pkg::DATA_W-1:0] tmp_a;
  logic [i8008_pkg::DATA_W-1:0] tmp_b;

  assign d_out = bus; // Internal bus goes straight out

  fsm_decoder u_fsm (
    .clk, .rst, .ready, .instr, .flags, .ctrl, .state, .sync
  );

  bus_datapath u_datapath (
    .clk, .rst, .ctrl, .d_in, .pc_byte, .rf_out, .alu_out,
    .bus, .tmp_a, .tmp_b, .instr
  );

  reg_file u_rf (
    .clk, .rst, .ctrl, .bus, .rf_out
  );

  alu u_alu (
    .clk, .rst, .ctrl, .tmp_a, .tmp_b, .alu_out, .flags
  );

  program_counter u_pc (
    .clk, .rst, .ctrl, .bus, .pc_byte
  );

endmodule

`default_nettype wire

// File: design/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
  input  logic                         clk,
  input  logic                         rst,
  input  i8008_pkg::ctrl_t             ctrl,
  input  logic [i8008_pkg::DATA_W-1:0] bus,
  output logic [i8008_pkg::DATA_W-1:0] pc_byte
);

  localparam int HI_W = i8008_pkg::ADDR_W - i8008_pkg::DATA_W;

  logic [i8008_pkg::ADDR_W-1:0] pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (ctrl.pc_inc) begin
      pc <= pc + 1'b1;
    end else begin
      if (ctrl.pc_ld_lo) pc[i8008_pkg::DATA_W-1:0] <= bus;
      if (ctrl.pc_ld_hi) pc[i8008_pkg::ADDR_W-1:i8008_pkg::DATA_W] <= bus[HI_W-1:0];
    end
  end

  // T2 byte carries the cycle type above the six high address bits
  assign pc_byte = ctrl.pc_hi_sel ? {ctrl.ctype, pc[i8008_pkg::ADDR_W-1:i8008_pkg::DATA_W]}
                                  : pc[i8008_pkg::DATA_W-1:0];

  a_inc_xor_load: assert property (@(posedge clk) disable iff (rst)
    ctrl.pc_inc |-> !(ctrl.pc_ld_lo || ctrl.pc_ld_hi))
    else $error("program counter increment and load in the same state");

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic                         clk,
  input  logic                         rst,
  input  i8008_pkg::ctrl_t             ctrl,
  input  logic [i8008_pkg::DATA_W-1:0] tmp_a,
  input  logic [i8008_pkg::DATA_W-1:0] tmp_b,
  output logic [i8008_pkg::DATA_W-1:0] alu_out,
  output i8008_pkg::flags_t            flags
);

  logic [i8008_pkg::DATA_W:0]   sum;   // Top bit is carry or borrow
  logic [i8008_pkg::DATA_W-1:0] res;
  logic                         cy;
  i8008_pkg::flags_t            flags_nxt;

  always_comb begin
    sum = '0;
    res = tmp_a;
    cy = flags.carry;
    if (ctrl.alu_arith) begin
      if (ctrl.alu_op == i8008_pkg::ADD) begin
        res = tmp_a + 8'd1;
      end else if (ctrl.alu_op == i8008_pkg::SUB) begin
        res = tmp_a - 8'd1;
      end else begin
        case (ctrl.rot_op)
          i8008_pkg::RLC: {cy, res} = {tmp_a[7], tmp_a[6:0], tmp_a[7]};
          i8008_pkg::RRC: {cy, res} = {tmp_a[0], tmp_a[0], tmp_a[7:1]};
          i8008_pkg::RAL: {cy, res} = {tmp_a, flags.carry};   // Through carry
          default:        {res, cy} = {flags.carry, tmp_a};
        endcase
      end
    end else begin
      case (ctrl.alu_op)
        i8008_pkg::ADD: sum = {1'b0, tmp_a} + {1'b0, tmp_b};
        i8008_pkg::ADC: sum = {1'b0, tmp_a} + {1'b0, tmp_b} + {8'd0, flags.carry};
        i8008_pkg::SBB: sum = {1'b0, tmp_a} - {1'b0, tmp_b} - {8'd0, flags.carry};
        i8008_pkg::AND: sum = {1'b0, tmp_a & tmp_b};
        i8008_pkg::XOR: sum = {1'b0, tmp_a ^ tmp_b};
        i8008_pkg::OR:  sum = {1'b0, tmp_a | tmp_b};
        default:        sum = {1'b0, tmp_a} - {1'b0, tmp_b};   // SUB and CMP
      endcase
      res = sum[i8008_pkg::DATA_W-1:0];
      cy = sum[i8008_pkg::DATA_W];
    end
  end

  // Compare only sets flags
  assign alu_out = (!ctrl.alu_arith && ctrl.alu_op == i8008_pkg::CMP) ? tmp_a : res;

  always_comb begin
    flags_nxt.carry = cy;
    flags_nxt.zero = ~|res;
    flags_nxt.sign = res[i8008_pkg::DATA_W-1];
    flags_nxt.parity = ~^res;   // Even number of ones
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      case (ctrl.flag_mode)
        i8008_pkg::FM_ALL:      flags <= flags_nxt;
        i8008_pkg::FM_NO_CARRY: flags <= {flags.carry, flags_nxt.zero, flags_nxt.sign,
                                          flags_nxt.parity};
        i8008_pkg::FM_CARRY:    flags.carry <= cy;
        default:                flags <= flags;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                         clk,
  input  logic                         rst,
  input  i8008_pkg::ctrl_t             ctrl,
  input  logic [i8008_pkg::DATA_W-1:0] bus,
  output logic [i8008_pkg::DATA_W-1:0] rf_out
);

  logic [i8008_pkg::DATA_W-1:0] regs [i8008_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < i8008_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.rf_we) begin
      regs[ctrl.rf_sel] <= bus;
    end
  end

  // Code 7 has no register behind it
  assign rf_out = (ctrl.rf_sel == i8008_pkg::REG_M) ? '0 : regs[ctrl.rf_sel];

  a_no_m_write: assert property (@(posedge clk) disable iff (rst)
    ctrl.rf_we |-> ctrl.rf_sel != i8008_pkg::REG_M)
    else $error("register write addressed to the memory code");

endmodule

`default_nettype wire

// File: design/bus_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module bus_datapath (
  input  logic                         clk,
  input  logic                         rst,
  input  i8008_pkg::ctrl_t             ctrl,
  input  logic [i8008_pkg::DATA_W-1:0] d_in,
  input  logic [i8008_pkg::DATA_W-1:0] pc_byte,
  input  logic [i8008_pkg::DATA_W-1:0] rf_out,
  input  logic [i8008_pkg::DATA_W-1:0] alu_out,
  output logic [i8008_pkg::DATA_W-1:0] bus,
  output logic [i8008_pkg::DATA_W-1:0] tmp_a,
  output logic [i8008_pkg::DATA_W-1:0] tmp_b,
  output i8008_pkg::instr_u            instr
);

  logic [i8008_pkg::DATA_W-1:0] ir_q;

  always_comb begin
    case (ctrl.bus_src)
      i8008_pkg::PC_BYTE: bus = pc_byte;
      i8008_pkg::REG:     bus = rf_out;
      i8008_pkg::ALU:     bus = alu_out;
      i8008_pkg::TMP_A:   bus = tmp_a;
      i8008_pkg::TMP_B:   bus = tmp_b;
      i8008_pkg::DIN:     bus = d_in;
      i8008_pkg::INSTR:   bus = ir_q;
      default:            bus = '0;   // Idle bus
    endcase
  end

  // Opcode is visible to the decoder already in the T3 that fetches it
  assign instr = ctrl.ir_we ? d_in : ir_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir_q <= '0;
    end else if (ctrl.ir_we) begin
      ir_q <= d_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.tmp_a_we) tmp_a <= bus;
    if (ctrl.tmp_b_we) tmp_b <= bus;
  end

  a_ir_only_pci: assert property (@(posedge clk) disable iff (rst)
    ctrl.ir_we |-> ctrl.ctype == i8008_pkg::PCI)
    else $error("instruction register loaded outside a PCI cycle");

endmodule

`default_nettype wire

// File: design/fsm_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module fsm_decoder (
  input  logic              clk,
  input  logic              rst,
  input  logic              ready,
  input  i8008_pkg::instr_u instr,
  input  i8008_pkg::flags_t flags,
  output i8008_pkg::ctrl_t  ctrl,
  output i8008_pkg::state_t state,
  output logic              sync
);

  i8008_pkg::state_t next_state;
  i8008_pkg::cycle_t cycle;
  i8008_pkg::cycle_t next_cycle;
  i8008_pkg::ctype_t cyc_type;
  logic [1:0] cls;
  logic [2:0] ddd;
  logic [2:0] sss;
  logic is_hlt, is_mov, is_alur, is_lri, is_alui, is_incdec, is_rot;
  logic is_jmp, is_jcc, is_out, out_cyc;
  logic cond_flag, taken;

  assign cls = instr.reg_view.cls;
  assign ddd = instr.reg_view.ddd;
  assign sss = instr.reg_view.sss;
  assign sync = (state == i8008_pkg::T1) || (state == i8008_pkg::T2);

  // Memory operand forms, calls, returns and INP decode to nothing
  always_comb begin
    is_hlt = (instr == i8008_pkg::OP_HLT0) || (instr == i8008_pkg::OP_HLT1) ||
             (instr == i8008_pkg::OP_HLT2);
    is_mov = (cls == i8008_pkg::CLS_MOV) && (ddd != i8008_pkg::REG_M) &&
             (sss != i8008_pkg::REG_M);
    is_alur = (cls == i8008_pkg::CLS_ALU) && (sss != i8008_pkg::REG_M);
    is_lri = (cls == i8008_pkg::CLS_IMM) && (sss == 3'b110) && (ddd != i8008_pkg::REG_M);
    is_alui = (cls == i8008_pkg::CLS_IMM) && (sss == 3'b100);
    is_incdec = (cls == i8008_pkg::CLS_IMM) && (sss[2:1] == 2'b00) &&
                (ddd != i8008_pkg::REG_A) && (ddd != i8008_pkg::REG_M);
    is_rot = (cls == i8008_pkg::CLS_IMM) && (sss == 3'b010) && !ddd[2];
    is_jmp = (instr.cond_view.cls == i8008_pkg::CLS_JMP) &&
             (instr.cond_view.sub == i8008_pkg::OP_JMP[2:0]);
    is_jcc = (instr.cond_view.cls == i8008_pkg::CLS_JMP) && (instr.cond_view.sub == 3'b000);
    is_out = ((instr & i8008_pkg::OP_OUT_MASK) == {i8008_pkg::CLS_JMP, 6'b000001}) &&
             (ddd[2:1] != 2'b00);
  end

  always_comb begin
    case (instr.cond_view.cond)
      2'd0:    cond_flag = flags.carry;
      2'd1:    cond_flag = flags.zero;
      2'd2:    cond_flag = flags.sign;
      default: cond_flag = flags.parity;
    endcase
    taken = (cond_flag == instr.cond_view.sense);
  end

  assign out_cyc = (cycle == i8008_pkg::CYC2) && is_out;

  always_comb begin
    case (cycle)
      i8008_pkg::CYC1: cyc_type = i8008_pkg::PCI;
      i8008_pkg::CYC2: cyc_type = is_out ? i8008_pkg::PCC : i8008_pkg::PCR;
      default:         cyc_type = i8008_pkg::PCR;
    endcase
  end

  always_comb begin
    next_state = state;
    next_cycle = cycle;
    case (state)
      i8008_pkg::T1: next_state = i8008_pkg::T2;
      i8008_pkg::T2: begin
        if (out_cyc) begin
          next_state = i8008_pkg::T1;  // PCC cycle has no T3
          next_cycle = i8008_pkg::CYC1;
        end else begin
          next_state = ready ? i8008_pkg::T3 : i8008_pkg::WAIT;
        end
      end
      i8008_pkg::WAIT: next_state = ready ? i8008_pkg::T3 : i8008_pkg::WAIT;
      i8008_pkg::T3: begin
        next_state = i8008_pkg::T4;
        if (cycle == i8008_pkg::CYC1) begin
          if (is_hlt) begin
            next_state = i8008_pkg::STOPPED;
          end else if (is_lri || is_alui || is_jmp || is_jcc || is_out) begin
            next_state = i8008_pkg::T1;
            next_cycle = i8008_pkg::CYC2;
          end
        end else if (cycle == i8008_pkg::CYC2) begin
          if (is_jmp || is_jcc) begin
            next_state = i8008_pkg::T1;
            next_cycle = i8008_pkg::CYC3;
          end
        end else if (is_jcc && !taken) begin
          next_state = i8008_pkg::T1;
          next_cycle = i8008_pkg::CYC1;
        end
      end
      i8008_pkg::T4: next_state = i8008_pkg::T5;
      i8008_pkg::STOPPED: next_state = i8008_pkg::STOPPED;  // Left only by reset
      default: begin
        next_state = i8008_pkg::T1;
        next_cycle = i8008_pkg::CYC1;
      end
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.ctype = cyc_type;
    case (state)
      i8008_pkg::T1: ctrl.bus_src = out_cyc ? i8008_pkg::TMP_A : i8008_pkg::PC_BYTE;
      i8008_pkg::T2: begin
        if (out_cyc) begin
          ctrl.bus_src = i8008_pkg::INSTR;
        end else begin
          ctrl.bus_src = i8008_pkg::PC_BYTE;
          ctrl.pc_hi_sel = 1'b1;
          ctrl.pc_inc = 1'b1;
        end
      end
      i8008_pkg::T3: begin
        if (cycle == i8008_pkg::CYC1) begin
          // Accumulator preloads tmp_a while the opcode is latched
          ctrl.bus_src = i8008_pkg::REG;
          ctrl.rf_sel = i8008_pkg::REG_A;
          ctrl.tmp_a_we = 1'b1;
          ctrl.ir_we = 1'b1;
        end else begin
          ctrl.bus_src = i8008_pkg::DIN;
          ctrl.tmp_b_we = (cycle == i8008_pkg::CYC2);  // Immediate or low address
          ctrl.tmp_a_we = (cycle == i8008_pkg::CYC3);  // High address
        end
      end
      i8008_pkg::T4: begin
        if (cycle == i8008_pkg::CYC3) begin
          ctrl.bus_src = i8008_pkg::TMP_A;
          ctrl.pc_ld_hi = 1'b1;
        end else if (cycle == i8008_pkg::CYC1 && (is_mov || is_alur)) begin
          ctrl.bus_src = i8008_pkg::REG;
          ctrl.rf_sel = sss;
          ctrl.tmp_b_we = 1'b1;
        end else if (cycle == i8008_pkg::CYC1 && is_incdec) begin
          ctrl.bus_src = i8008_pkg::REG;
          ctrl.rf_sel = ddd;
          ctrl.tmp_a_we = 1'b1;
        end
      end
      i8008_pkg::T5: begin
        if (cycle == i8008_pkg::CYC3) begin
          ctrl.bus_src = i8008_pkg::TMP_B;
          ctrl.pc_ld_lo = 1'b1;
        end else if ((cycle == i8008_pkg::CYC1 && is_mov) ||
                     (cycle == i8008_pkg::CYC2 && is_lri)) begin
          ctrl.bus_src = i8008_pkg::TMP_B;
          ctrl.rf_sel = ddd;
          ctrl.rf_we = 1'b1;
        end else if ((cycle == i8008_pkg::CYC1 && is_alur) ||
                     (cycle == i8008_pkg::CYC2 && is_alui)) begin
          ctrl.bus_src = i8008_pkg::ALU;
          ctrl.rf_sel = i8008_pkg::REG_A;
          ctrl.rf_we = 1'b1;
          ctrl.alu_op = i8008_pkg::alu_op_t'(ddd);
          ctrl.flag_mode = i8008_pkg::FM_ALL;
        end else if (cycle == i8008_pkg::CYC1 && (is_incdec || is_rot)) begin
          ctrl.bus_src = i8008_pkg::ALU;
          ctrl.rf_sel = is_rot ? i8008_pkg::REG_A : ddd;
          ctrl.rf_we = 1'b1;
          ctrl.alu_arith = 1'b1;
          if (is_rot) begin
            ctrl.alu_op = i8008_pkg::CMP;
            ctrl.rot_op = i8008_pkg::rot_op_t'(ddd[1:0]);
            ctrl.flag_mode = i8008_pkg::FM_CARRY;
          end else begin
            ctrl.alu_op = sss[0] ? i8008_pkg::SUB : i8008_pkg::ADD;
            ctrl.flag_mode = i8008_pkg::FM_NO_CARRY;
          end
        end
      end
      default: ctrl.bus_src = i8008_pkg::NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= i8008_pkg::T1;
      cycle <= i8008_pkg::CYC1;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state inside {i8008_pkg::T1, i8008_pkg::T2, i8008_pkg::WAIT, i8008_pkg::T3,
                  i8008_pkg::T4, i8008_pkg::T5, i8008_pkg::STOPPED})
    else $error("state register holds an unused encoding");

  a_no_mem_operand: assert property (@(posedge clk) disable iff (rst)
    (ctrl.rf_we || ctrl.bus_src == i8008_pkg::REG) |-> ctrl.rf_sel != i8008_pkg::REG_M)
    else $error("register access decoded with the memory code");

endmodule

`default_nettype wire

// File: design/i8008_pkg.sv
`default_nettype none

package i8008_pkg;

  localparam int DATA_W    = 8;
  localparam int ADDR_W    = 14;
  localparam int NUM_REGS  = 7;
  localparam int REG_SEL_W = 3;
  localparam int FLAG_W    = 4;

  // Scratchpad indices
  localparam logic [REG_SEL_W-1:0] REG_A = 3'd0;
  localparam logic [REG_SEL_W-1:0] REG_H = 3'd5;
  localparam logic [REG_SEL_W-1:0] REG_L = 3'd6;
  localparam logic [REG_SEL_W-1:0] REG_M = 3'd7; // Memory operand code

  localparam logic [DATA_W-1:0] OP_HLT0     = 8'h00;
  localparam logic [DATA_W-1:0] OP_HLT1     = 8'h01;
  localparam logic [DATA_W-1:0] OP_HLT2     = 8'hFF;
  localparam logic [DATA_W-1:0] OP_JMP      = 8'h44;
  localparam logic [DATA_W-1:0] OP_OUT_MASK = 8'hC1; // 01 RRMMM 1 with RR nonzero

  // Top two opcode bits
  localparam logic [1:0] CLS_IMM = 2'b00;
  localparam logic [1:0] CLS_JMP = 2'b01;
  localparam logic [1:0] CLS_ALU = 2'b10;
  localparam logic [1:0] CLS_MOV = 2'b11;

  // Same codes as the 8008 S2..S0 state pins
  typedef enum logic [2:0] {
    T1      = 3'b010,
    T2      = 3'b001,
    WAIT    = 3'b000,
    T3      = 3'b100,
    T4      = 3'b111,
    T5      = 3'b101,
    STOPPED = 3'b110
  } state_t;

  typedef enum logic [1:0] {CYC1, CYC2, CYC3} cycle_t;

  typedef enum logic [1:0] {
    PCI = 2'b00,
    PCR = 2'b10,
    PCC = 2'b01,
    PCW = 2'b11
  } ctype_t;

  typedef enum logic [2:0] {ADD, ADC, SUB, SBB, AND, XOR, OR, CMP} alu_op_t;

  typedef enum logic [1:0] {RLC, RRC, RAL, RAR} rot_op_t;

  typedef enum logic [1:0] {FM_NONE, FM_ALL, FM_NO_CARRY, FM_CARRY} flag_mode_t;

  typedef enum logic [2:0] {NONE, PC_BYTE, REG, ALU, TMP_A, TMP_B, DIN, INSTR} bus_src_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic parity;
  } flags_t;

  typedef union packed {
    struct packed {
      logic [1:0] cls;
      logic [2:0] ddd;
      logic [2:0] sss;
    } reg_view;
    struct packed {
      logic [1:0] cls;
      logic       sense;   // 1 jumps on a set flag
      logic [1:0] cond;    // Carry, zero, sign, parity
      logic [2:0] sub;
    } cond_view;
  } instr_u;

  // With alu_arith set, ADD and SUB step tmp_a by one and other codes rotate
  typedef struct packed {
    bus_src_t             bus_src;
    logic                 rf_we;
    logic [REG_SEL_W-1:0] rf_sel;
    logic                 tmp_a_we;
    logic                 tmp_b_we;
    logic                 ir_we;
    logic                 alu_arith;
    alu_op_t              alu_op;
    rot_op_t              rot_op;
    flag_mode_t           flag_mode;
    logic                 pc_inc;
    logic                 pc_ld_lo;
    logic                 pc_ld_hi;
    logic                 pc_hi_sel;
    ctype_t               ctype;
  } ctrl_t;

endpackage

`default_nettype wire
